// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_tqv_periph_top \
    -f tqv_periph_top.f -o tb_sim > build.log 2>&1 &&
    ./obj_dir/tb_sim > sim.log 2>&1 ||
    { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -qx "TB PASSED" sim.log &&
    echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }

// File: src/gpio_ctrl.sv
//##########################################################################
// GPIO slot: output register, input readback and per-pin select.
// Each output pin follows bit n of any slot's pin byte.
// Select writes take the low 5 bits; unknown offsets read as zero.
//##########################################################################

`timescale 1ns/10ps

module gpio_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_wr,
    input  logic [5:0]        i_offset,
    input  periph_pkg::word_t i_wdata,
    input  logic [7:0]        i_ui_in,
    input  logic [7:0]        i_user_pins   [periph_pkg::NUM_SLOTS],
    input  logic [7:0]        i_simple_pins [periph_pkg::NUM_SLOTS],
    output periph_pkg::word_t o_rdata,
    output logic [7:0]        o_uo_out
);

    logic [7:0]            gpio_out;
    periph_pkg::func_sel_t func_sel [periph_pkg::GPIO_PINS];
    logic                  is_sel;
    logic [2:0]            sel_idx;

    // Selects sit at 0x20 + 4n
    assign is_sel  = ((i_offset & 6'h23) == periph_pkg::GPIO_SEL_BASE);
    assign sel_idx = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (i_wr && i_offset == periph_pkg::GPIO_OUT_OFS) begin
            gpio_out <= i_wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < periph_pkg::GPIO_PINS; p++) begin
                if (p < 2) begin
                    func_sel[p] <= periph_pkg::SEL_RESET_LOW;
                end else begin
                    func_sel[p] <= {1'b0, periph_pkg::SLOT_GPIO};
                end
            end
        end else if (i_wr && is_sel) begin
            func_sel[sel_idx] <= i_wdata[4:0];
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_offset == periph_pkg::GPIO_OUT_OFS) begin
            o_rdata = {24'h0, gpio_out};
        end else if (i_offset == periph_pkg::GPIO_IN_OFS) begin
            o_rdata = {24'h0, i_ui_in};
        end else if (is_sel) begin
            o_rdata = {27'h0, func_sel[sel_idx]};
        end
    end

    // Output pin multiplexer
    always_comb begin
        for (int p = 0; p < periph_pkg::GPIO_PINS; p++) begin
            if (func_sel[p][4]) begin
                o_uo_out[p] = i_simple_pins[func_sel[p][3:0]][p];
            end else if (func_sel[p][3:0] == periph_pkg::SLOT_GPIO) begin
                // Own slot drives straight from the output register
                o_uo_out[p] = gpio_out[p];
            end else begin
                o_uo_out[p] = i_user_pins[func_sel[p][3:0]][p];
            end
        end
    end

endmodule

// File: src/periph_addr_decode.sv
//##########################################################################
// Address and size decode for the peripheral bus.
// Bit 10 of the address picks the simple bank, else the user bank.
// Read strobes are masked while a registered read result is pending.
//##########################################################################

`timescale 1ns/10ps

module periph_addr_decode (
    input  logic [periph_pkg::ADDR_W-1:0] i_addr,
    input  periph_pkg::size_t             i_data_write_n,
    input  periph_pkg::size_t             i_data_read_n,
    input  logic                          i_read_busy,
    output logic [15:0]                   o_user_sel,
    output logic [15:0]                   o_simple_sel,
    output logic [15:0]                   o_user_wr,
    output logic [15:0]                   o_user_rd,
    output logic [15:0]                   o_simple_wr,
    output periph_pkg::mask_t             o_wr_mask,
    output logic                          o_read_req
);

    periph_pkg::slot_t user_slot;
    periph_pkg::slot_t simple_slot;
    logic              write_req;
    logic              slot_read;

    assign user_slot   = i_addr[9:6];
    assign simple_slot = i_addr[7:4];

    always_comb begin
        o_user_sel   = '0;
        o_simple_sel = '0;
        if (i_addr[10]) begin
            o_simple_sel[simple_slot] = 1'b1;
        end else begin
            o_user_sel[user_slot] = 1'b1;
        end
    end

    assign write_req  = (i_data_write_n != periph_pkg::SIZE_NONE);
    assign o_read_req = (i_data_read_n != periph_pkg::SIZE_NONE);

    // No new read reaches a slot while the result is being returned
    assign slot_read = o_read_req && !i_read_busy;

    assign o_user_wr   = o_user_sel & {16{write_req}};
    assign o_user_rd   = o_user_sel & {16{slot_read}};
    assign o_simple_wr = o_simple_sel & {16{write_req}};

    always_comb begin
        case (i_data_write_n)
            periph_pkg::SIZE_B: o_wr_mask = 4'b0001;
            periph_pkg::SIZE_H: o_wr_mask = 4'b0011;
            periph_pkg::SIZE_W: o_wr_mask = 4'b1111;
            default:            o_wr_mask = 4'b0000;
        endcase
    end

endmodule

// File: src/periph_pkg.sv
//##########################################################################
// Shared widths, size codes and slot map of the peripheral bus wrapper.
// User slots are 64 bytes, simple slots 16 bytes and byte wide.
// Size codes follow the core: 00 byte, 01 half, 10 word, 11 idle.
//##########################################################################

package periph_pkg;

    localparam int ADDR_W = 11;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // Read and write size codes from the core
    typedef logic [1:0] size_t;
    localparam size_t SIZE_B    = 2'b00;
    localparam size_t SIZE_H    = 2'b01;
    localparam size_t SIZE_W    = 2'b10;
    localparam size_t SIZE_NONE = 2'b11;

    typedef logic [3:0] slot_t;
    localparam int NUM_SLOTS = 16;

    // Bit 4 picks the simple bank, bits 3..0 the slot in that bank
    typedef logic [4:0] func_sel_t;

    typedef logic [3:0] mask_t;

    // Populated slots
    localparam slot_t SLOT_GPIO     = 4'd1;
    localparam slot_t SLOT_SCR_WAIT = 4'd2;
    localparam slot_t SLOT_SCR_FAST = 4'd3;
    localparam slot_t SLOT_BYTE0    = 4'd0;
    localparam slot_t SLOT_BYTE1    = 4'd1;

    // GPIO register offsets inside its user slot
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] GPIO_SEL_BASE = 6'h20;
    localparam int         GPIO_PINS     = 8;

    // Pins 0 and 1 start on the slow scratch slot
    localparam func_sel_t SEL_RESET_LOW = {1'b0, SLOT_SCR_WAIT};

endpackage

// File: src/read_return.sv
//##########################################################################
// Registered read-return path to the core.
// Read data is captured once and held until the read-complete pulse.
// Ready lags the slot by one cycle; writes are acknowledged at once.
//##########################################################################

`timescale 1ns/10ps

module read_return (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_read_req,
    input  logic [15:0]       i_user_sel,
    input  logic [15:0]       i_simple_sel,
    input  periph_pkg::word_t i_user_rdata  [periph_pkg::NUM_SLOTS],
    input  logic [15:0]       i_user_ready,
    input  periph_pkg::byte_t i_simple_rdata [periph_pkg::NUM_SLOTS],
    input  logic              i_data_read_complete,
    input  logic              i_write_req,
    output periph_pkg::word_t o_data,
    output logic              o_data_ready,
    output logic              o_read_busy
);

    periph_pkg::word_t peri_data;
    logic              peri_ready;
    logic              data_hold;
    logic              ready_r;
    logic              capture;

    // Selects are one-hot, so a priority loop acts as a plain mux
    always_comb begin
        peri_data  = '0;
        peri_ready = 1'b0;
        for (int s = 0; s < periph_pkg::NUM_SLOTS; s++) begin
            if (i_user_sel[s]) begin
                peri_data  = i_user_rdata[s];
                peri_ready = i_user_ready[s];
            end
            if (i_simple_sel[s]) begin
                peri_data  = {24'h0, i_simple_rdata[s]};
                peri_ready = 1'b1;
            end
        end
    end

    assign capture = i_read_req && peri_ready && !data_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold <= 1'b0;
            ready_r   <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                data_hold <= 1'b0;
            end
            if (capture) begin
                data_hold <= 1'b1;
            end
            ready_r <= i_read_req && peri_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_data <= peri_data;
        end
    end

    assign o_read_busy  = ready_r;
    assign o_data_ready = ready_r || i_write_req;

endmodule

// File: src/scratch_regs.sv
//##########################################################################
// Four scratch registers with byte-masked writes, cleared on reset.
// Payload width must be a whole number of bytes, up to 32 bits.
// Read data is combinational; ready follows READ_WAIT cycles after a
// read strobe rises and drops as soon as the strobe goes low.
//##########################################################################

`timescale 1ns/10ps

module scratch_regs #(
    parameter type         payload_t = periph_pkg::word_t,
    parameter int unsigned READ_WAIT = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_wr,
    input  logic              i_rd,
    input  logic [1:0]        i_index,
    input  payload_t          i_wdata,
    input  periph_pkg::mask_t i_wr_mask,
    output payload_t          o_rdata,
    output logic              o_ready,
    output logic [7:0]        o_pin
);

    localparam int NUM_BYTES = $bits(payload_t) / 8;
    localparam int CNT_W     = $clog2(READ_WAIT + 2);

    payload_t         regs [4];
    logic [CNT_W-1:0] wait_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 4; r++) begin
                regs[r] <= '0;
            end
        end else if (i_wr) begin
            // Only the bytes enabled by the size mask change
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (i_wr_mask[b]) begin
                    regs[i_index][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Wait counter restarts whenever the read strobe drops
    always_ff @(posedge clk) begin
        if (!rst_n || !i_rd) begin
            wait_cnt <= '0;
        end else if (wait_cnt != CNT_W'(READ_WAIT)) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign o_ready = i_rd && (wait_cnt == CNT_W'(READ_WAIT));
    assign o_rdata = regs[i_index];

    // Register 0 low byte doubles as this slot's pin byte
    assign o_pin = regs[0][7:0];

endmodule

// File: src/tqv_periph_top.sv
//##########################################################################
// Peripheral bus wrapper: decode, GPIO, scratch slots and read return.
// User slots 2 and 3 hold word scratch registers, simple slots 0 and 1
// byte scratch registers. Other slots read zero and are always ready.
//##########################################################################

`timescale 1ns/10ps

module tqv_periph_top #(
    parameter int unsigned SCR_WAIT = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [periph_pkg::ADDR_W-1:0] i_addr,
    input  periph_pkg::word_t             i_data,
    input  periph_pkg::size_t             i_data_write_n,
    input  periph_pkg::size_t             i_data_read_n,
    input  logic                          i_data_read_complete,
    input  logic [7:0]                    i_ui_in,
    output periph_pkg::word_t             o_data,
    output logic                          o_data_ready,
    output logic [7:0]                    o_uo_out
);

    logic [15:0]       user_sel;
    logic [15:0]       simple_sel;
    logic [15:0]       user_wr;
    logic [15:0]       user_rd;
    logic [15:0]       simple_wr;
    periph_pkg::mask_t wr_mask;
    logic              read_req;
    logic              read_busy;

    periph_pkg::word_t user_rdata   [periph_pkg::NUM_SLOTS];
    logic [15:0]       user_ready;
    logic [7:0]        user_pins    [periph_pkg::NUM_SLOTS];
    periph_pkg::byte_t simple_rdata [periph_pkg::NUM_SLOTS];
    logic [7:0]        simple_pins  [periph_pkg::NUM_SLOTS];

    periph_addr_decode u_decode (
        .i_addr         (i_addr),
        .i_data_write_n (i_data_write_n),
        .i_data_read_n  (i_data_read_n),
        .i_read_busy    (read_busy),
        .o_user_sel     (user_sel),
        .o_simple_sel   (simple_sel),
        .o_user_wr      (user_wr),
        .o_user_rd      (user_rd),
        .o_simple_wr    (simple_wr),
        .o_wr_mask      (wr_mask),
        .o_read_req     (read_req)
    );

    // Unpopulated slots read zero, answer at once and drive no pins
    for (genvar s = 0; s < periph_pkg::NUM_SLOTS; s++) begin : g_empty
        if (s != periph_pkg::SLOT_GPIO && s != periph_pkg::SLOT_SCR_WAIT &&
            s != periph_pkg::SLOT_SCR_FAST) begin : g_user
            assign user_rdata[s] = '0;
            assign user_ready[s] = 1'b1;
            assign user_pins[s]  = '0;
        end
        if (s != periph_pkg::SLOT_BYTE0 && s != periph_pkg::SLOT_BYTE1) begin : g_simple
            assign simple_rdata[s] = '0;
            assign simple_pins[s]  = '0;
        end
    end

    // GPIO pin byte comes from inside gpio_ctrl
    assign user_ready[periph_pkg::SLOT_GPIO] = 1'b1;
    assign user_pins[periph_pkg::SLOT_GPIO]  = '0;

    gpio_ctrl u_gpio (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_wr          (user_wr[periph_pkg::SLOT_GPIO]),
        .i_offset      (i_addr[5:0]),
        .i_wdata       (i_data),
        .i_ui_in       (i_ui_in),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_rdata       (user_rdata[periph_pkg::SLOT_GPIO]),
        .o_uo_out      (o_uo_out)
    );

    scratch_regs #(.payload_t(periph_pkg::word_t), .READ_WAIT(SCR_WAIT)) u_scr_wait (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr      (user_wr[periph_pkg::SLOT_SCR_WAIT]),
        .i_rd      (user_rd[periph_pkg::SLOT_SCR_WAIT]),
        .i_index   (i_addr[3:2]),
        .i_wdata   (i_data),
        .i_wr_mask (wr_mask),
        .o_rdata   (user_rdata[periph_pkg::SLOT_SCR_WAIT]),
        .o_ready   (user_ready[periph_pkg::SLOT_SCR_WAIT]),
        .o_pin     (user_pins[periph_pkg::SLOT_SCR_WAIT])
    );

    scratch_regs #(.payload_t(periph_pkg::word_t), .READ_WAIT(0)) u_scr_fast (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr      (user_wr[periph_pkg::SLOT_SCR_FAST]),
        .i_rd      (user_rd[periph_pkg::SLOT_SCR_FAST]),
        .i_index   (i_addr[3:2]),
        .i_wdata   (i_data),
        .i_wr_mask (wr_mask),
        .o_rdata   (user_rdata[periph_pkg::SLOT_SCR_FAST]),
        .o_ready   (user_ready[periph_pkg::SLOT_SCR_FAST]),
        .o_pin     (user_pins[periph_pkg::SLOT_SCR_FAST])
    );

    // Byte slots are always ready, so their ready output stays open
    scratch_regs #(.payload_t(periph_pkg::byte_t), .READ_WAIT(0)) u_byte0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr      (simple_wr[periph_pkg::SLOT_BYTE0]),
        .i_rd      (simple_sel[periph_pkg::SLOT_BYTE0]),
        .i_index   (i_addr[1:0]),
        .i_wdata   (i_data[7:0]),
        .i_wr_mask (wr_mask),
        .o_rdata   (simple_rdata[periph_pkg::SLOT_BYTE0]),
        .o_ready   (),
        .o_pin     (simple_pins[periph_pkg::SLOT_BYTE0])
    );

    scratch_regs #(.payload_t(periph_pkg::byte_t), .READ_WAIT(0)) u_byte1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr      (simple_wr[periph_pkg::SLOT_BYTE1]),
        .i_rd      (simple_sel[periph_pkg::SLOT_BYTE1]),
        .i_index   (i_addr[1:0]),
        .i_wdata   (i_data[7:0]),
        .i_wr_mask (wr_mask),
        .o_rdata   (simple_rdata[periph_pkg::SLOT_BYTE1]),
        .o_ready   (),
        .o_pin     (simple_pins[periph_pkg::SLOT_BYTE1])
    );

    // A non-zero mask means a write is on the bus
    read_return u_read_return (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_read_req           (read_req),
        .i_user_sel           (user_sel),
        .i_simple_sel         (simple_sel),
        .i_user_rdata         (user_rdata),
        .i_user_ready         (user_ready),
        .i_simple_rdata       (simple_rdata),
        .i_data_read_complete (i_data_read_complete),
        .i_write_req          (|wr_mask),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready),
        .o_read_busy          (read_busy)
    );

endmodule

// File: testbench/tb_tqv_periph_top.sv
//##########################################################################
// Random testbench for the peripheral bus wrapper, LFSR seed 32'hddee.
// A model of GPIO, selects and scratch registers predicts reads and pins.
// Slot 2 read latency is checked against SCR_WAIT + 1 cycles.
//##########################################################################

`timescale 1ns/10ps

module tb_tqv_periph_top;

    localparam int SCR_WAIT = 2;
    localparam int N_RANDOM = 400;
    localparam int N_OPS    = N_RANDOM + 20;
    localparam int MAX_WAIT = 20;

    logic                          clk;
    logic                          rst_n;
    logic [periph_pkg::ADDR_W-1:0] i_addr;
    periph_pkg::word_t             i_data;
    periph_pkg::size_t             i_data_write_n;
    periph_pkg::size_t             i_data_read_n;
    logic                          i_data_read_complete;
    logic [7:0]                    i_ui_in;
    periph_pkg::word_t             o_data;
    logic                          o_data_ready;
    logic [7:0]                    o_uo_out;

    // Reference model state
    logic [31:0]           lfsr_state;
    periph_pkg::word_t     scr_m  [2][4];
    periph_pkg::byte_t     byte_m [2][4];
    logic [7:0]            gpio_out_m;
    periph_pkg::func_sel_t sel_m  [8];
    int                    checks;
    int                    mismatches;
    int                    other_errors;

    tqv_periph_top #(.SCR_WAIT(SCR_WAIT)) tqv_periph_top_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data               (i_data),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .i_ui_in              (i_ui_in),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready),
        .o_uo_out             (o_uo_out)
    );

    always #4 clk = ~clk;

    initial begin
        repeat (N_OPS * 16 + 100) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", N_OPS * 16 + 100);
        $display("TB FAILED");
        $finish;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < n; i++) begin
            bit_out    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (bit_out) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            value = {value[30:0], bit_out};
        end
        return value;
    endfunction

    function automatic periph_pkg::size_t rand_size();
        periph_pkg::size_t size;
        size = 2'(lfsr_bits(2));
        if (size == periph_pkg::SIZE_NONE) begin
            size = periph_pkg::SIZE_W;
        end
        return size;
    endfunction

    function automatic logic [10:0] user_addr(input periph_pkg::slot_t slot,
                                              input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic logic [10:0] simple_addr(input periph_pkg::slot_t slot,
                                                input logic [3:0] ofs);
        return {3'b100, slot, ofs};
    endfunction

    function automatic void model_write(input logic [10:0] addr, input periph_pkg::word_t data,
                                        input periph_pkg::size_t size);
        periph_pkg::mask_t mask;
        logic [5:0]        ofs;
        mask = (size == periph_pkg::SIZE_B) ? 4'b0001 :
               (size == periph_pkg::SIZE_H) ? 4'b0011 : 4'b1111;
        ofs  = addr[5:0];
        if (addr[10]) begin
            // Byte slots take the low byte for every size
            if (addr[7:4] < 4'd2) begin
                byte_m[addr[4]][addr[1:0]] = data[7:0];
            end
        end else if (addr[9:6] == periph_pkg::SLOT_GPIO) begin
            if (ofs == periph_pkg::GPIO_OUT_OFS) begin
                gpio_out_m = data[7:0];
            end else if (ofs[5] && ofs[1:0] == 2'b00) begin
                sel_m[ofs[4:2]] = data[4:0];
            end
        end else if (addr[9:6] == periph_pkg::SLOT_SCR_WAIT ||
                     addr[9:6] == periph_pkg::SLOT_SCR_FAST) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    scr_m[addr[6]][addr[3:2]][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
    endfunction

    function automatic periph_pkg::word_t model_read(input logic [10:0] addr);
        periph_pkg::word_t value;
        logic [5:0]        ofs;
        value = '0;
        ofs   = addr[5:0];
        if (addr[10]) begin
            if (addr[7:4] < 4'd2) begin
                value = {24'h0, byte_m[addr[4]][addr[1:0]]};
            end
        end else if (addr[9:6] == periph_pkg::SLOT_GPIO) begin
            if (ofs == periph_pkg::GPIO_OUT_OFS) begin
                value = {24'h0, gpio_out_m};
            end else if (ofs == periph_pkg::GPIO_IN_OFS) begin
                value = {24'h0, i_ui_in};
            end else if (ofs[5] && ofs[1:0] == 2'b00) begin
                value = {27'h0, sel_m[ofs[4:2]]};
            end
        end else if (addr[9:6] == periph_pkg::SLOT_SCR_WAIT ||
                     addr[9:6] == periph_pkg::SLOT_SCR_FAST) begin
            value = scr_m[addr[6]][addr[3:2]];
        end
        return value;
    endfunction

    // Pin n shows bit n of the pin byte of the slot its select names
    function automatic periph_pkg::byte_t model_pins();
        periph_pkg::byte_t pins;
        periph_pkg::byte_t src;
        pins = '0;
        for (int p = 0; p < 8; p++) begin
            if (sel_m[p][4]) begin
                src = (sel_m[p][3:0] < 4'd2) ? byte_m[sel_m[p][0]][0] : 8'h00;
            end else begin
                case (sel_m[p][3:0])
                    periph_pkg::SLOT_GPIO:     src = gpio_out_m;
                    periph_pkg::SLOT_SCR_WAIT: src = scr_m[0][0][7:0];
                    periph_pkg::SLOT_SCR_FAST: src = scr_m[1][0][7:0];
                    default:                   src = 8'h00;
                endcase
            end
            pins[p] = src[p];
        end
        return pins;
    endfunction

    task automatic compare_word(input string name, input periph_pkg::word_t got,
                                input periph_pkg::word_t expected);
        checks++;
        if (got !== expected) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic compare_byte(input string name, input periph_pkg::byte_t got,
                                input periph_pkg::byte_t expected);
        checks++;
        if (got !== expected) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_latency(input logic [10:0] addr, input int got, input int expected);
        checks++;
        if (got != expected) begin
            mismatches++;
            $display("mismatch read latency at %h: got %0h expected %0h", addr, got, expected);
        end
    endtask

    task automatic check_pins();
        compare_byte("o_uo_out", o_uo_out, model_pins());
    endtask

    task automatic bus_write(input logic [10:0] addr, input periph_pkg::word_t data,
                             input periph_pkg::size_t size);
        i_addr         = addr;
        i_data         = data;
        i_data_write_n = size;
        #1;
        if (o_data_ready !== 1'b1) begin
            other_errors++;
            $display("write to address %h was not acknowledged in its own cycle", addr);
        end
        model_write(addr, data, size);
        @(posedge clk);
        #1;
        i_data_write_n = periph_pkg::SIZE_NONE;
        check_pins();
    endtask

    task automatic bus_read(input logic [10:0] addr);
        periph_pkg::word_t expected;
        int                latency;
        int                exp_latency;
        expected    = model_read(addr);
        exp_latency = (!addr[10] && addr[9:6] == periph_pkg::SLOT_SCR_WAIT) ? SCR_WAIT + 1 : 1;
        latency       = 0;
        i_addr        = addr;
        i_data_read_n = rand_size();
        // Ready must still be low in the request cycle itself
        #1;
        while (!o_data_ready && latency < MAX_WAIT) begin
            @(posedge clk);
            #1;
            latency++;
        end
        if (!o_data_ready) begin
            other_errors++;
            $display("read at address %h got no ready within %0d cycles", addr, MAX_WAIT);
        end else begin
            check_latency(addr, latency, exp_latency);
            compare_word($sformatf("o_data from %h", addr), o_data, expected);
        end
        // Request stays one more cycle while the input port moves under it
        i_ui_in = ~i_ui_in;
        @(posedge clk);
        #1;
        compare_word("o_data held", o_data, expected);
        i_data_read_n        = periph_pkg::SIZE_NONE;
        i_data_read_complete = 1'b1;
        @(posedge clk);
        #1;
        i_data_read_complete = 1'b0;
        check_pins();
    endtask

    task automatic empty_access(input logic [3:0] slot, input logic [1:0] idx,
                                input periph_pkg::word_t data, input periph_pkg::size_t size);
        logic [10:0] addr;
        if (idx[0]) begin
            addr = user_addr((slot >= 4'd1 && slot <= 4'd3) ? slot + 4'd4 : slot, data[13:8]);
        end else begin
            addr = simple_addr((slot < 4'd2) ? slot + 4'd2 : slot, data[11:8]);
        end
        if (idx[1]) begin
            bus_write(addr, data, size);
        end else begin
            bus_read(addr);
        end
    endtask

    task automatic random_op();
        logic [2:0]        kind;
        logic [3:0]        slot;
        logic [1:0]        idx;
        periph_pkg::word_t data;
        periph_pkg::size_t size;
        periph_pkg::slot_t scr_slot;
        logic [5:0]        sel_ofs;
        kind     = 3'(lfsr_bits(3));
        slot     = 4'(lfsr_bits(4));
        idx      = 2'(lfsr_bits(2));
        data     = lfsr_bits(32);
        size     = rand_size();
        scr_slot = slot[0] ? periph_pkg::SLOT_SCR_FAST : periph_pkg::SLOT_SCR_WAIT;
        sel_ofs  = periph_pkg::GPIO_SEL_BASE + {1'b0, slot[2:0], 2'b00};
        case (kind)
            3'd0: bus_write(user_addr(scr_slot, {2'b00, idx, 2'b00}), data, size);
            3'd1: bus_read(user_addr(scr_slot, {2'b00, idx, 2'b00}));
            3'd2: bus_write(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT_OFS), data, size);
            3'd3: bus_write(user_addr(periph_pkg::SLOT_GPIO, sel_ofs), data, size);
            3'd4: begin
                i_ui_in = data[7:0];
                if (idx == 2'd0) begin
                    bus_read(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT_OFS));
                end else if (idx == 2'd1) begin
                    bus_read(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_IN_OFS));
                end else begin
                    bus_read(user_addr(periph_pkg::SLOT_GPIO, sel_ofs));
                end
            end
            3'd5: bus_write(simple_addr({3'b000, slot[0]}, {2'b00, idx}), data, size);
            3'd6: bus_read(simple_addr({3'b000, slot[0]}, {2'b00, idx}));
            default: empty_access(slot, idx, data, size);
        endcase
    endtask

    initial begin
        clk                  = 1'b0;
        rst_n                = 1'b0;
        i_addr               = '0;
        i_data               = '0;
        i_data_write_n       = periph_pkg::SIZE_NONE;
        i_data_read_n        = periph_pkg::SIZE_NONE;
        i_data_read_complete = 1'b0;
        i_ui_in              = '0;
        lfsr_state           = 32'hddee;
        checks               = 0;
        mismatches           = 0;
        other_errors         = 0;
        gpio_out_m           = '0;
        for (int s = 0; s < 2; s++) begin
            for (int r = 0; r < 4; r++) begin
                scr_m[s][r]  = '0;
                byte_m[s][r] = '0;
            end
        end
        for (int p = 0; p < 8; p++) begin
            sel_m[p] = (p < 2) ? {1'b0, periph_pkg::SLOT_SCR_WAIT} :
                                 {1'b0, periph_pkg::SLOT_GPIO};
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_pins();

        // Reset state of selects and output register
        for (int p = 0; p < 8; p++) begin
            bus_read(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_SEL_BASE + 6'(4 * p)));
        end
        bus_read(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT_OFS));

        // Slow and fast scratch latency while pins 0 and 1 follow slot 2
        bus_write(user_addr(periph_pkg::SLOT_SCR_WAIT, 6'h00), 32'ha5c3_0f96, periph_pkg::SIZE_W);
        bus_read(user_addr(periph_pkg::SLOT_SCR_WAIT, 6'h00));
        bus_read(user_addr(periph_pkg::SLOT_SCR_FAST, 6'h04));

        bus_write(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT_OFS), 32'h5a,
                  periph_pkg::SIZE_B);
        bus_read(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT_OFS));
        i_ui_in = 8'h3c;
        bus_read(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_IN_OFS));

        // Unpopulated slots
        bus_read(user_addr(4'd0, 6'h08));
        bus_read(user_addr(4'd9, 6'h00));
        bus_read(simple_addr(4'd7, 4'h2));
        bus_write(user_addr(4'd12, 6'h10), 32'hdead_beef, periph_pkg::SIZE_W);

        repeat (N_RANDOM) random_op();

        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tqv_periph_top.f
src/periph_pkg.sv
src/periph_addr_decode.sv
src/scratch_regs.sv
src/gpio_ctrl.sv
src/read_return.sv
src/tqv_periph_top.sv
testbench/tb_tqv_periph_top.sv
